/* hdl/beam_pkg.sv */
package beam_pkg;

    // Array geometry and sample format
    localparam int DATA_WIDTH    = 16;
    localparam int NUM_CHANNELS  = 8;
    localparam int CHAN_WIDTH    = 3;
    localparam int MAX_DELAY     = 64;
    localparam int DELAY_WIDTH   = 6;
    // One extra bit per doubling of the channel count, so the sum never overflows
    localparam int SUM_WIDTH     = DATA_WIDTH + CHAN_WIDTH;

    // Focal point in sample units, element k sits at k * ELEMENT_PITCH
    localparam int POS_WIDTH     = 16;
    localparam int ELEMENT_PITCH = 8;

    // Focus calculator states
    localparam logic [2:0] CALC_IDLE    = 3'd0;
    localparam logic [2:0] CALC_SQUARE  = 3'd1;
    localparam logic [2:0] CALC_DIVIDE  = 3'd2;
    localparam logic [2:0] CALC_LOAD    = 3'd3;
    localparam logic [2:0] CALC_ACK     = 3'd4;
    localparam logic [2:0] CALC_RELEASE = 3'd5;

    // Serial summer states
    localparam logic [1:0] SUM_IDLE    = 2'd0;
    localparam logic [1:0] SUM_CAPTURE = 2'd1;
    localparam logic [1:0] SUM_SUMMING = 2'd2;
    localparam logic [1:0] SUM_DONE    = 2'd3;

    // RF sample of one channel
    typedef logic signed [DATA_WIDTH-1:0] sample_t;

    // Beam sum over all channels
    typedef logic signed [SUM_WIDTH-1:0] sum_t;

    // Integer delay in sample instants
    typedef logic [DELAY_WIDTH-1:0] delay_t;

    // Channel index
    typedef logic [CHAN_WIDTH-1:0] chan_t;

endpackage

/* hdl/focus_delay_calc.sv */
`timescale 1ns/100ps

module focus_delay_calc (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req,
    input  logic [beam_pkg::POS_WIDTH-1:0] x_f,
    input  logic [beam_pkg::POS_WIDTH-1:0] z_f,
    output logic                           ack,
    output logic                           busy,
    output logic                           load,
    output beam_pkg::chan_t                load_channel,
    output beam_pkg::delay_t               load_delay
);
    import beam_pkg::*;

    logic [2:0]                       state;
    chan_t                            channel;
    logic [$clog2(2*POS_WIDTH)-1:0]   bit_cnt;

    logic [POS_WIDTH-1:0]             x_lat;
    logic [POS_WIDTH-1:0]             z_lat;
    logic [POS_WIDTH-1:0]             elem_pos;
    logic [POS_WIDTH-1:0]             dx;
    logic [POS_WIDTH:0]               divisor;

    // Dividend shifts out the top while quotient bits shift in at the bottom
    logic [2*POS_WIDTH-1:0]           quot;
    logic [POS_WIDTH:0]               rem;
    logic [POS_WIDTH+1:0]             trial;
    logic [POS_WIDTH+1:0]             diff;
    logic                             q_bit;
    delay_t                           delay_clamped;

    // Lateral distance from the focal point to the current element
    assign elem_pos = POS_WIDTH'(channel) * POS_WIDTH'(ELEMENT_PITCH);
    assign dx       = (x_lat >= elem_pos) ? (x_lat - elem_pos) : (elem_pos - x_lat);

    // Parabolic delay is dx^2 / (2 * z_f)
    assign divisor  = {z_lat, 1'b0};

    // One restoring step
    assign trial = {rem, quot[2*POS_WIDTH-1]};
    assign diff  = trial - {1'b0, divisor};
    assign q_bit = (trial >= {1'b0, divisor});

    // A zero divisor leaves an all-ones quotient, which clamps to the maximum here
    assign delay_clamped = (|quot[2*POS_WIDTH-1:DELAY_WIDTH]) ?
                           delay_t'(MAX_DELAY - 1) : quot[DELAY_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= CALC_IDLE;
            channel <= '0;
            bit_cnt <= '0;
            ack     <= 1'b0;
            busy    <= 1'b0;
            load    <= 1'b0;
        end else begin
            load <= 1'b0;
            case (state)
                CALC_IDLE: begin
                    if (req && !ack) begin
                        busy    <= 1'b1;
                        channel <= '0;
                        state   <= CALC_SQUARE;
                    end
                end
                CALC_SQUARE: begin
                    bit_cnt <= '0;
                    state   <= CALC_DIVIDE;
                end
                CALC_DIVIDE: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == ($clog2(2*POS_WIDTH))'(2*POS_WIDTH - 1)) begin
                        state <= CALC_LOAD;
                    end
                end
                CALC_LOAD: begin
                    load <= 1'b1;
                    if (channel == chan_t'(NUM_CHANNELS - 1)) begin
                        state <= CALC_ACK;
                    end else begin
                        channel <= channel + 1'b1;
                        state   <= CALC_SQUARE;
                    end
                end
                CALC_ACK: begin
                    // All lines hold their new delays by now
                    ack   <= 1'b1;
                    busy  <= 1'b0;
                    state <= CALC_RELEASE;
                end
                CALC_RELEASE: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= CALC_IDLE;
                    end
                end
                default: begin
                    state <= CALC_IDLE;
                end
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        case (state)
            CALC_IDLE: begin
                if (req && !ack) begin
                    x_lat <= x_f;
                    z_lat <= z_f;
                end
            end
            CALC_SQUARE: begin
                quot <= (2*POS_WIDTH)'(dx) * (2*POS_WIDTH)'(dx);
                rem  <= '0;
            end
            CALC_DIVIDE: begin
                quot <= {quot[2*POS_WIDTH-2:0], q_bit};
                rem  <= q_bit ? diff[POS_WIDTH:0] : trial[POS_WIDTH:0];
            end
            CALC_LOAD: begin
                load_channel <= channel;
                load_delay   <= delay_clamped;
            end
            default: begin
            end
        endcase
    end

endmodule

/* hdl/channel_delay_line.sv */
`timescale 1ns/100ps

module channel_delay_line #(
    parameter beam_pkg::chan_t CHANNEL = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  beam_pkg::sample_t sample_in,
    input  logic              load,
    input  beam_pkg::chan_t   load_channel,
    input  beam_pkg::delay_t  load_delay,
    output beam_pkg::sample_t tap
);
    import beam_pkg::*;

    // Circular history of the last MAX_DELAY samples
    sample_t              mem [MAX_DELAY];
    logic [MAX_DELAY-1:0] written;
    delay_t               wr_ptr;
    delay_t               rd_ptr;
    delay_t               cur_delay;

    // Wraps for free since MAX_DELAY is a power of two
    assign rd_ptr = wr_ptr - cur_delay;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            written   <= '0;
            cur_delay <= '0;
        end else begin
            if (load && (load_channel == CHANNEL)) begin
                cur_delay <= load_delay;
            end
            if (push) begin
                written[wr_ptr] <= 1'b1;
                wr_ptr          <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= sample_in;
            // Zero delay taps the sample being written this cycle
            if (cur_delay == '0) begin
                tap <= sample_in;
            end else if (written[rd_ptr]) begin
                tap <= mem[rd_ptr];
            end else begin
                // Nothing pushed there since reset
                tap <= '0;
            end
        end
    end

endmodule

/* hdl/serial_beam_sum.sv */
`timescale 1ns/100ps

module serial_beam_sum (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 accept,
    input  logic                                                 busy,
    input  logic [beam_pkg::NUM_CHANNELS*beam_pkg::DATA_WIDTH-1:0] taps,
    output logic                                                 sample_ready,
    output beam_pkg::sum_t                                       beam_out,
    output logic                                                 beam_valid
);
    import beam_pkg::*;

    logic [1:0]                       state;
    logic [1:0]                       next_state;
    chan_t                            channel;
    logic                             ready_q;
    logic [NUM_CHANNELS*DATA_WIDTH-1:0] taps_q;
    sample_t                          current_sample;
    sum_t                             acc;

    // Selected channel from the snapshot
    assign current_sample = sample_t'(taps_q[channel*DATA_WIDTH +: DATA_WIDTH]);

    // No new sample while delays change or a sum is running
    assign sample_ready = ready_q && !busy;

    always_comb begin
        next_state = state;
        case (state)
            SUM_IDLE: begin
                if (accept) begin
                    next_state = SUM_CAPTURE;
                end
            end
            SUM_CAPTURE: next_state = SUM_SUMMING;
            SUM_SUMMING: begin
                if (channel == chan_t'(NUM_CHANNELS - 1)) begin
                    next_state = SUM_DONE;
                end
            end
            SUM_DONE:    next_state = SUM_IDLE;
            default:     next_state = SUM_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= SUM_IDLE;
            channel    <= '0;
            ready_q    <= 1'b0;
            beam_valid <= 1'b0;
        end else begin
            state      <= next_state;
            // Ready and valid rise on the same edge
            ready_q    <= (next_state == SUM_IDLE);
            beam_valid <= (state == SUM_DONE);
            if (state == SUM_SUMMING) begin
                channel <= channel + 1'b1;
            end else begin
                channel <= '0;
            end
        end
    end

    // Snapshot, accumulate with sign extension, then publish
    always_ff @(posedge clk) begin
        case (state)
            SUM_CAPTURE: begin
                taps_q <= taps;
                acc    <= '0;
            end
            SUM_SUMMING: acc <= acc + sum_t'(current_sample);
            SUM_DONE:    beam_out <= acc;
            default: begin
            end
        endcase
    end

endmodule

/* hdl/beamformer_top.sv */
`timescale 1ns/100ps

module beamformer_top (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 req,
    input  logic [beam_pkg::POS_WIDTH-1:0]                       x_f,
    input  logic [beam_pkg::POS_WIDTH-1:0]                       z_f,
    input  logic [beam_pkg::NUM_CHANNELS*beam_pkg::DATA_WIDTH-1:0] rf_data,
    input  logic                                                 sample_valid,
    output logic                                                 ack,
    output logic                                                 sample_ready,
    output beam_pkg::sum_t                                       beam_out,
    output logic                                                 beam_valid
);
    import beam_pkg::*;

    logic                               busy;
    logic                               load;
    chan_t                              load_channel;
    delay_t                             load_delay;
    logic                               accept;
    logic [NUM_CHANNELS*DATA_WIDTH-1:0] taps;

    // One sample instant enters every line and the summer together
    assign accept = sample_valid && sample_ready;

    focus_delay_calc focus_calc_i (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .x_f          (x_f),
        .z_f          (z_f),
        .ack          (ack),
        .busy         (busy),
        .load         (load),
        .load_channel (load_channel),
        .load_delay   (load_delay)
    );

    for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_channel
        channel_delay_line #(
            .CHANNEL (chan_t'(k))
        ) delay_line_i (
            .clk          (clk),
            .reset        (reset),
            .push         (accept),
            .sample_in    (rf_data[k*DATA_WIDTH +: DATA_WIDTH]),
            .load         (load),
            .load_channel (load_channel),
            .load_delay   (load_delay),
            .tap          (taps[k*DATA_WIDTH +: DATA_WIDTH])
        );
    end

    serial_beam_sum beam_sum_i (
        .clk          (clk),
        .reset        (reset),
        .accept       (accept),
        .busy         (busy),
        .taps         (taps),
        .sample_ready (sample_ready),
        .beam_out     (beam_out),
        .beam_valid   (beam_valid)
    );

endmodule

/* verif/beamformer_tb.sv */
`timescale 1ns/100ps

module beamformer_tb;
    import beam_pkg::*;

    logic                               clk;
    logic                               reset;
    logic                               req;
    logic [POS_WIDTH-1:0]               x_f;
    logic [POS_WIDTH-1:0]               z_f;
    logic [NUM_CHANNELS*DATA_WIDTH-1:0] rf_data;
    logic                               sample_valid;
    logic                               ack;
    logic                               sample_ready;
    sum_t                               beam_out;
    logic                               beam_valid;

    // Trace records, one entry per F or S line
    logic [7:0]                         kind_q [$];
    logic [POS_WIDTH-1:0]               x_q [$];
    logic [POS_WIDTH-1:0]               z_q [$];
    logic [NUM_CHANNELS*DATA_WIDTH-1:0] rf_q [$];
    sum_t                               beam_q [$];

    int   seed;
    int   watchdog_cycles;
    logic trace_loaded = 1'b0;

    beamformer_top beamformer_top_i (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .x_f          (x_f),
        .z_f          (z_f),
        .rf_data      (rf_data),
        .sample_valid (sample_valid),
        .ack          (ack),
        .sample_ready (sample_ready),
        .beam_out     (beam_out),
        .beam_valid   (beam_valid)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic check_sum(input string name, input sum_t expected, input sum_t actual);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("Regression failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display("Regression failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic load_trace();
        int                                 fd;
        int                                 code;
        logic                               reading;
        logic [7:0]                         tag;
        string                              rest;
        logic [POS_WIDTH-1:0]               x_val;
        logic [POS_WIDTH-1:0]               z_val;
        sample_t                            smp [NUM_CHANNELS];
        sum_t                               expected;
        logic [NUM_CHANNELS*DATA_WIDTH-1:0] packed_rf;
        fd = $fopen("verif/beamformer_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file verif/beamformer_trace.txt");
        end
        reading = 1'b1;
        while (reading) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                reading = 1'b0;
            end else if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "F") begin
                code = $fscanf(fd, "%h %h", x_val, z_val);
                kind_q.push_back(tag);
                x_q.push_back(x_val);
                z_q.push_back(z_val);
                rf_q.push_back('0);
                beam_q.push_back('0);
            end else if (tag == "S") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", smp[0], smp[1], smp[2],
                               smp[3], smp[4], smp[5], smp[6], smp[7], expected);
                for (int k = 0; k < NUM_CHANNELS; k++) begin
                    packed_rf[k*DATA_WIDTH +: DATA_WIDTH] = smp[k];
                end
                kind_q.push_back(tag);
                x_q.push_back('0);
                z_q.push_back('0);
                rf_q.push_back(packed_rf);
                beam_q.push_back(expected);
            end else begin
                abort_run("The trace file holds a line of unknown kind");
            end
        end
        $fclose(fd);
    endtask

    // Four-phase focus handshake with sample_ready held low while delays are computed
    task automatic apply_focus(input logic [POS_WIDTH-1:0] x_val,
                               input logic [POS_WIDTH-1:0] z_val);
        check_bit("ack", 1'b0, ack);
        @(posedge clk);
        x_f <= x_val;
        z_f <= z_val;
        req <= 1'b1;
        // Latch edge
        @(posedge clk);
        @(negedge clk);
        while (!ack) begin
            check_bit("sample_ready", 1'b0, sample_ready);
            @(negedge clk);
        end
        check_bit("sample_ready", 1'b1, sample_ready);
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_bit("ack", 1'b1, ack);
        // Dropped on the first edge that sees req low
        @(negedge clk);
        check_bit("ack", 1'b0, ack);
    endtask

    task automatic send_sample(input logic [NUM_CHANNELS*DATA_WIDTH-1:0] data,
                               input sum_t expected);
        int gap;
        gap = $random(seed) & 32'h3;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        rf_data      <= data;
        sample_valid <= 1'b1;
        @(negedge clk);
        while (!sample_ready) begin
            @(negedge clk);
        end
        // Junk stays valid after the accept edge and must be refused while the sum runs
        @(posedge clk);
        rf_data <= {$random(seed), $random(seed), $random(seed), $random(seed)};
        for (int i = 0; i < NUM_CHANNELS + 2; i++) begin
            @(negedge clk);
            check_bit("beam_valid", 1'b0, beam_valid);
            check_bit("sample_ready", 1'b0, sample_ready);
        end
        // Withdrawn on the edge where sample_ready rises again
        @(posedge clk);
        sample_valid <= 1'b0;
        @(negedge clk);
        check_bit("beam_valid", 1'b1, beam_valid);
        check_bit("sample_ready", 1'b1, sample_ready);
        check_sum("beam_out", expected, beam_out);
        @(negedge clk);
        check_bit("beam_valid", 1'b0, beam_valid);
        check_sum("beam_out", expected, beam_out);
    endtask

    initial begin
        seed         = 32'habb06ef3;
        clk          = 1'b0;
        reset        = 1'b1;
        req          = 1'b0;
        x_f          = '0;
        z_f          = '0;
        rf_data      = '0;
        sample_valid = 1'b0;
        load_trace();
        watchdog_cycles = 200 * kind_q.size() + 10;
        trace_loaded    = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("ack", 1'b0, ack);
        check_bit("beam_valid", 1'b0, beam_valid);
        check_bit("sample_ready", 1'b0, sample_ready);
        @(negedge clk);
        check_bit("sample_ready", 1'b1, sample_ready);
        for (int i = 0; i < kind_q.size(); i++) begin
            if (kind_q[i] == "F") begin
                apply_focus(x_q[i], z_q[i]);
            end else begin
                send_sample(rf_q[i], beam_q[i]);
            end
        end
        $display("Regression passed");
        $finish;
    end

    // Budget grows with the number of trace records
    initial begin
        wait (trace_loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* verif/beamformer_trace.txt */
# Columns of an F line are the tag, x_f and z_f, in hex
# Columns of an S line are the tag, samples of channels 0 to 7 and the expected beam, in hex
# No focus yet so every delay is zero
S 0010 0011 0012 0013 0014 0015 0016 0017 0009c
S 0020 0021 0022 0023 0024 0025 0026 0027 0011c
S 0030 0031 0032 0033 0034 0035 0036 0037 0019c
S 0040 0041 0042 0043 0044 0045 0046 0047 0021c
# x_f 28 and z_f 32 give delays 12 6 2 0 0 2 6 12
F 001c 0020
S 0050 0051 0052 0053 0054 0055 0056 0057 0010e
S 0060 0061 0062 0063 0064 0065 0066 0067 0014e
S 0070 0071 0072 0073 0074 0075 0076 0077 001b5
S 0080 0081 0082 0083 0084 0085 0086 0087 00215
S 0090 0091 0092 0093 0094 0095 0096 0097 00275
S 00a0 00a1 00a2 00a3 00a4 00a5 00a6 00a7 002d5
S 00b0 00b1 00b2 00b3 00b4 00b5 00b6 00b7 00335
S 00c0 00c1 00c2 00c3 00c4 00c5 00c6 00c7 00395
# Refocus mid-stream at x_f 16 and z_f 64, delays 2 0 0 0 2 4 8 12 on the kept history
F 0010 0040
S 00d0 00d1 00d2 00d3 00d4 00d5 00d6 00d7 004dc
S 00e0 00e1 00e2 00e3 00e4 00e5 00e6 00e7 0055c
S 00f0 00f1 00f2 00f3 00f4 00f5 00f6 00f7 005dc
S 0100 0101 0102 0103 0104 0105 0106 0107 0065c
S 0110 0111 0112 0113 0114 0115 0116 0117 006dc
# z_f zero clamps every delay to 63, no entry that old exists yet
F 001c 0000
S 0120 0121 0122 0123 0124 0125 0126 0127 00000
S 0130 0131 0132 0133 0134 0135 0136 0137 00000
S 0140 0141 0142 0143 0144 0145 0146 0147 00000
# Very deep focus brings every delay back to zero
F 001c ffff
# Full-scale negative, full-scale positive, then alternating
S 8000 8000 8000 8000 8000 8000 8000 8000 40000
S 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 3fff8
S 8000 7fff 8000 7fff 8000 7fff 8000 7fff 7fffc

/* beamformer.f */
hdl/beam_pkg.sv
hdl/focus_delay_calc.sv
hdl/channel_delay_line.sv
hdl/serial_beam_sum.sv
hdl/beamformer_top.sv
verif/beamformer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f beamformer.f --top-module beamformer_tb -o beamformer_sim

# The simulator exits nonzero on a failure, the log decides the result
./obj_dir/beamformer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "Regression passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
